/* list.f */
design/cur_buf_pkg.sv
design/fetch_sequencer.sv
design/swap_control.sv
design/pingpong_store.sv
design/row_transition_mux.sv
design/cur_block_buffer.sv
bench/cur_block_buffer_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the current-block buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module cur_block_buffer_tb \
    -f list.f \
    -o cur_block_buffer_tb

output="$(./obj_dir/cur_block_buffer_tb)"
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

/* bench/cur_block_buffer_tb.sv */
`default_nettype none

module cur_block_buffer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int seed     = 83880;
    localparam int n_random = 6;

    logic                   clk;
    logic                   rst;
    logic                   en;
    logic                   next_block;
    cur_buf_pkg::word_t     cur_in;
    cur_buf_pkg::block_t    cur_out;
    cur_buf_pkg::mem_addr_t cur_mem_addr;

    // model of the two stores and the sequencing around them
    cur_buf_pkg::word_t     m_words [2][16];
    logic                   m_half;
    logic                   m_trans;
    int                     m_step;
    logic                   m_cold;
    logic                   m_active;
    int                     m_idx;
    cur_buf_pkg::mem_addr_t m_addr;

    // address that the memory word on cur_in was taken from
    cur_buf_pkg::mem_addr_t seen_addr;

    int          errors;
    int          timeouts;
    logic [31:0] rng;

    cur_block_buffer dut_i (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .next_block   (next_block),
        .cur_in       (cur_in),
        .cur_out      (cur_out),
        .cur_mem_addr (cur_mem_addr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory contents, a hash over the full address
    function automatic cur_buf_pkg::word_t mem_word(input cur_buf_pkg::mem_addr_t addr);
        return xorshift32(xorshift32(addr ^ 32'(seed)));
    endfunction

    // the 16 words fetched from base upward, word i at bit 32*i
    function automatic cur_buf_pkg::block_t block_from(input cur_buf_pkg::mem_addr_t base);
        cur_buf_pkg::block_t b;
        b = '0;
        for (int i = 0; i < 16; i++) begin
            b[i*32 +: 32] = mem_word(base + 32'(4 * i));
        end
        return b;
    endfunction

    function automatic cur_buf_pkg::block_t expected_block(input logic en_now);
        cur_buf_pkg::block_t b;
        int                  cur_sel;
        int                  src;
        b = '0;
        if (en_now) begin
            cur_sel = m_half ? 1 : 0;
            for (int r = 0; r < 8; r++) begin
                // rows past the step still show the other store
                src = (!m_trans || r <= m_step) ? cur_sel : 1 - cur_sel;
                b[r*64 +: 32]      = m_words[src][2*r];
                b[r*64 + 32 +: 32] = m_words[src][2*r + 1];
            end
        end
        return b;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory model, answers the address seen before each rising edge
    initial begin
        cur_in    = '0;
        seen_addr = '0;
        forever begin
            @(negedge clk);
            seen_addr = cur_mem_addr;
            cur_in    = mem_word(cur_mem_addr);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 2; s++) begin
                for (int i = 0; i < 16; i++) begin
                    m_words[s][i] = '0;
                end
            end
            m_half   = 1'b0;
            m_trans  = 1'b0;
            m_step   = 0;
            m_cold   = 1'b1;
            m_active = 1'b0;
            m_idx    = 0;
            m_addr   = '0;
        end else if (en) begin
            if (next_block || m_cold) begin
                m_cold   = 1'b0;
                m_half   = ~m_half;
                m_trans  = 1'b1;
                m_step   = 0;
                m_active = 1'b1;
                m_idx    = 0;
            end else begin
                if (m_trans) begin
                    if (m_step == 6) begin
                        m_trans = 1'b0;
                        m_step  = 0;
                    end else begin
                        m_step++;
                    end
                end
                if (m_active) begin
                    // the store that is not on display takes the word
                    m_words[m_half ? 0 : 1][m_idx] = mem_word(seen_addr);
                    m_addr = m_addr + 32'd4;
                    if (m_idx == 15) begin
                        m_active = 1'b0;
                    end else begin
                        m_idx++;
                    end
                end
            end
        end
    end

    // compare against the model once the edge has settled
    always @(posedge clk) begin
        #2;
        if (!rst) begin
            assert (cur_out === expected_block(en)) else begin
                errors++;
                $display("** Error at %0t: cur_out differs from model (en=%0b step=%0d)",
                    $time, en, m_step);
            end
            assert (cur_mem_addr === m_addr) else begin
                errors++;
                $display("** Error at %0t: cur_mem_addr %0h, model %0h",
                    $time, cur_mem_addr, m_addr);
            end
        end
    end

    // one start with en held high, crossover and fetch checked edge by edge
    task automatic follow_block(
        input logic                by_pulse,
        input cur_buf_pkg::block_t new_blk,
        input cur_buf_pkg::block_t old_blk
    );
        cur_buf_pkg::mem_addr_t base;
        cur_buf_pkg::mem_addr_t exp_addr;
        cur_buf_pkg::block_t    exp_blk;
        @(negedge clk);
        base       = cur_mem_addr;
        en         = 1'b1;
        next_block = by_pulse;
        for (int k = 0; k <= 17; k++) begin
            @(posedge clk);
            #2;
            exp_blk = new_blk;
            if (k <= 6) begin
                for (int r = k + 1; r < 8; r++) begin
                    exp_blk[r*64 +: 64] = old_blk[r*64 +: 64];
                end
            end
            exp_addr = base + 32'(4 * (k > 16 ? 16 : k));
            assert (cur_out === exp_blk) else begin
                errors++;
                $display("** Error at %0t: block view wrong %0d edges after start",
                    $time, k);
            end
            assert (cur_mem_addr === exp_addr) else begin
                errors++;
                $display("** Error at %0t: address %0h after %0d edges, expected %0h",
                    $time, cur_mem_addr, k, exp_addr);
            end
            @(negedge clk);
            next_block = 1'b0;
        end
    endtask

    // start a block, then drop en about one cycle in four until the fetch is done
    task automatic random_block();
        cur_buf_pkg::mem_addr_t target;
        int                     n;
        @(negedge clk);
        target     = cur_mem_addr + 32'd64;
        en         = 1'b1;
        next_block = 1'b1;
        @(negedge clk);
        next_block = 1'b0;
        n          = 0;
        while (cur_mem_addr != target && n < 200) begin
            rng = xorshift32(rng);
            en  = (rng[1:0] != 2'b00);
            @(negedge clk);
            n++;
        end
        en = 1'b1;
        if (cur_mem_addr != target) begin
            timeouts++;
            $display("timeout: fetch never reached address %0h", target);
        end
    endtask

    initial begin
        errors     = 0;
        timeouts   = 0;
        rng        = 32'(seed);
        rst        = 1'b1;
        en         = 1'b0;
        next_block = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        #2;
        assert (cur_mem_addr == 0 && cur_out == '0) else begin
            errors++;
            $display("** Error at %0t: state after reset not clear", $time);
        end

        // cold boot needs no pulse, both stores still empty
        follow_block(1'b0, '0, '0);
        follow_block(1'b1, block_from(32'd0), '0);
        follow_block(1'b1, block_from(32'd64), block_from(32'd0));

        for (int b = 0; b < n_random; b++) begin
            random_block();
        end

        // last two random fetches covered 448 and 512
        follow_block(1'b1, block_from(32'd512), block_from(32'd448));

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/cur_block_buffer.sv */
`default_nettype none

module cur_block_buffer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     en,
    input  wire                     next_block,
    input  wire cur_buf_pkg::word_t cur_in,
    output cur_buf_pkg::block_t     cur_out,
    output cur_buf_pkg::mem_addr_t  cur_mem_addr
);

    // fetch side
    logic                   block_start;
    logic                   word_wr;
    cur_buf_pkg::word_idx_t word_idx;

    // swap side
    logic                     half;
    logic                     in_transition;
    cur_buf_pkg::trans_step_t trans_step;

    // block stores
    cur_buf_pkg::block_t store_0;
    cur_buf_pkg::block_t store_1;

    fetch_sequencer fetch_i (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .next_block   (next_block),
        .block_start  (block_start),
        .word_wr      (word_wr),
        .word_idx     (word_idx),
        .cur_mem_addr (cur_mem_addr)
    );

    swap_control swap_i (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .block_start   (block_start),
        .half          (half),
        .in_transition (in_transition),
        .trans_step    (trans_step)
    );

    pingpong_store store_i (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .word_wr  (word_wr),
        .half     (half),
        .word_idx (word_idx),
        .cur_in   (cur_in),
        .store_0  (store_0),
        .store_1  (store_1)
    );

    row_transition_mux mux_i (
        .en            (en),
        .half          (half),
        .in_transition (in_transition),
        .trans_step    (trans_step),
        .store_0       (store_0),
        .store_1       (store_1),
        .cur_out       (cur_out)
    );

endmodule

`default_nettype wire

/* design/row_transition_mux.sv */
`default_nettype none

module row_transition_mux (
    input  wire                           en,
    input  wire                           half,
    input  wire                           in_transition,
    input  wire cur_buf_pkg::trans_step_t trans_step,
    input  wire cur_buf_pkg::block_t      store_0,
    input  wire cur_buf_pkg::block_t      store_1,
    output cur_buf_pkg::block_t           cur_out
);

    cur_buf_pkg::block_t cur_blk;
    cur_buf_pkg::block_t old_blk;

    // half picks the store that holds the current block
    assign cur_blk = half ? store_1 : store_0;
    assign old_blk = half ? store_0 : store_1;

    always_comb begin
        cur_out = '0;
        if (en) begin
            for (int r = 0; r < cur_buf_pkg::block_rows; r++) begin
                // during crossover rows 0..step are new, the rest still old
                if (!in_transition || r <= int'(trans_step)) begin
                    cur_out[r*cur_buf_pkg::row_w +: cur_buf_pkg::row_w] =
                        cur_blk[r*cur_buf_pkg::row_w +: cur_buf_pkg::row_w];
                end else begin
                    cur_out[r*cur_buf_pkg::row_w +: cur_buf_pkg::row_w] =
                        old_blk[r*cur_buf_pkg::row_w +: cur_buf_pkg::row_w];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/pingpong_store.sv */
`default_nettype none

module pingpong_store (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         en,
    input  wire                         word_wr,
    input  wire                         half,
    input  wire cur_buf_pkg::word_idx_t word_idx,
    input  wire cur_buf_pkg::word_t     cur_in,
    output cur_buf_pkg::block_t         store_0,
    output cur_buf_pkg::block_t         store_1
);

    cur_buf_pkg::block_t stores [2];
    logic                wr_sel;
    int                  wr_lsb;

    // the store not on display takes the fetch
    assign wr_sel = ~half;

    // word n lands at bit 32*n, so row r is words 2r and 2r+1
    assign wr_lsb = int'(word_idx) * cur_buf_pkg::word_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            stores[0] <= '0;
            stores[1] <= '0;
        end else if (en && word_wr) begin
            stores[wr_sel][wr_lsb +: cur_buf_pkg::word_w] <= cur_in;
        end
    end

    assign store_0 = stores[0];
    assign store_1 = stores[1];

endmodule

`default_nettype wire

/* design/swap_control.sv */
`default_nettype none

module swap_control (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      en,
    input  wire                      block_start,
    output logic                     half,
    output logic                     in_transition,
    output cur_buf_pkg::trans_step_t trans_step
);

    cur_buf_pkg::swap_state_e state;
    logic                     step_done;

    assign in_transition = (state == cur_buf_pkg::swap_transition);

    assign step_done =
        (trans_step == cur_buf_pkg::trans_step_t'(cur_buf_pkg::trans_last));

    always_ff @(posedge clk) begin
        if (rst) begin
            half       <= 1'b0;
            state      <= cur_buf_pkg::swap_steady;
            trans_step <= '0;
        end else if (en) begin
            if (block_start) begin
                // freshly filled store becomes current, crossover restarts
                half       <= ~half;
                state      <= cur_buf_pkg::swap_transition;
                trans_step <= '0;
            end else if (in_transition) begin
                if (step_done) begin
                    state      <= cur_buf_pkg::swap_steady;
                    trans_step <= '0;
                end else begin
                    trans_step <= trans_step + 1'b1;
                end
            end
        end
    end

    // step counter is parked at 0 outside a crossover
    a_steady_step : assert property (
        @(posedge clk) disable iff (rst)
        state == cur_buf_pkg::swap_steady |-> trans_step == '0
    );

endmodule

`default_nettype wire

/* design/fetch_sequencer.sv */
`default_nettype none

module fetch_sequencer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    en,
    input  wire                    next_block,
    output logic                   block_start,
    output logic                   word_wr,
    output cur_buf_pkg::word_idx_t word_idx,
    output cur_buf_pkg::mem_addr_t cur_mem_addr
);

    logic                      cold_boot;
    cur_buf_pkg::fetch_state_e state;
    logic                      last_word;

    // first enabled cycle after reset counts as a start
    assign block_start = en && (next_block || cold_boot);

    // the start edge only rearms the counter, words follow from the next edge
    assign word_wr = en && (state == cur_buf_pkg::fetch_active) && !block_start;

    assign last_word =
        (word_idx == cur_buf_pkg::word_idx_t'(cur_buf_pkg::words_per_block - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cold_boot    <= 1'b1;
            state        <= cur_buf_pkg::fetch_idle;
            word_idx     <= '0;
            cur_mem_addr <= '0;
        end else if (block_start) begin
            cold_boot <= 1'b0;
            state     <= cur_buf_pkg::fetch_active;
            word_idx  <= '0;
        end else if (word_wr) begin
            // address keeps running across blocks
            cur_mem_addr <= cur_mem_addr
                + cur_buf_pkg::mem_addr_t'(cur_buf_pkg::addr_step);
            if (last_word) begin
                state <= cur_buf_pkg::fetch_idle;
            end else begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // after a word write the fetch is either closed or the index has moved off 0
    a_no_wrap : assert property (
        @(posedge clk) disable iff (rst)
        word_wr |=> state == cur_buf_pkg::fetch_idle || word_idx != '0
    );

endmodule

`default_nettype wire

/* design/cur_buf_pkg.sv */
`default_nettype none

package cur_buf_pkg;

    // pixel and bus geometry
    localparam int pixel_w = 8;
    localparam int word_w  = 4 * pixel_w;
    localparam int row_w   = 8 * pixel_w;

    // block geometry, 8x8 pixels
    localparam int block_rows      = 8;
    localparam int block_w         = block_rows * row_w;
    localparam int words_per_block = block_w / word_w;

    // byte address increment per fetched word
    localparam int addr_step = word_w / pixel_w;

    // crossover shows rows 0..step of the new block, last step leaves one old row
    localparam int trans_last = block_rows - 2;

    typedef logic [word_w-1:0]  word_t;
    typedef logic [block_w-1:0] block_t;

    typedef logic [$clog2(words_per_block)-1:0] word_idx_t;
    typedef logic [$clog2(block_rows)-1:0]      trans_step_t;

    typedef logic [31:0] mem_addr_t;

    // word fetch from external memory
    typedef enum logic {
        fetch_idle,
        fetch_active
    } fetch_state_e;

    // output view of the two stores
    typedef enum logic {
        swap_steady,
        swap_transition
    } swap_state_e;

endpackage

`default_nettype wire
